// ==== ad9963_core.sv ====
module ad9963_core #(
  parameter int ID = 0
) (
  input  logic                            trx_clk,
  input  logic                            rst_n_i,
  // converter bus
  input  logic                            trx_iq_i,
  input  logic [ad9963_pkg::SAMPLE_W-1:0] trx_data_i,
  output logic                            tx_iq_o,
  output logic [ad9963_pkg::SAMPLE_W-1:0] tx_data_o,
  // dma receive
  output logic                            adc_enable_i_o,
  output logic                            adc_valid_i_o,
  output logic [ad9963_pkg::DMA_W-1:0]    adc_data_i_o,
  output logic                            adc_enable_q_o,
  output logic                            adc_valid_q_o,
  output logic [ad9963_pkg::DMA_W-1:0]    adc_data_q_o,
  input  logic                            adc_dovf_i,
  // dma transmit
  output logic                            dac_enable_i_o,
  output logic                            dac_valid_i_o,
  input  logic [ad9963_pkg::DMA_W-1:0]    dac_data_i_i,
  output logic                            dac_enable_q_o,
  output logic                            dac_valid_q_o,
  input  logic [ad9963_pkg::DMA_W-1:0]    dac_data_q_i,
  input  logic                            dac_dunf_i,
  // axi-lite
  input  logic                            s_axi_awvalid_i,
  input  logic [31:0]                     s_axi_awaddr_i,
  input  logic [2:0]                      s_axi_awprot_i,
  output logic                            s_axi_awready_o,
  input  logic                            s_axi_wvalid_i,
  input  logic [ad9963_pkg::DATA_W-1:0]   s_axi_wdata_i,
  input  logic [3:0]                      s_axi_wstrb_i,
  output logic                            s_axi_wready_o,
  output logic                            s_axi_bvalid_o,
  output logic [1:0]                      s_axi_bresp_o,
  input  logic                            s_axi_bready_i,
  input  logic                            s_axi_arvalid_i,
  input  logic [31:0]                     s_axi_araddr_i,
  input  logic [2:0]                      s_axi_arprot_i,
  output logic                            s_axi_arready_o,
  output logic                            s_axi_rvalid_o,
  output logic [ad9963_pkg::DATA_W-1:0]   s_axi_rdata_o,
  output logic [1:0]                      s_axi_rresp_o,
  input  logic                            s_axi_rready_i
);

  localparam int PW = 2 * ad9963_pkg::SAMPLE_W;

  logic          adc_valid;
  logic [PW-1:0] adc_data;
  logic          dac_valid;
  logic [PW-1:0] dac_data;

  up_bus_if up_rx_bus ();
  up_bus_if up_tx_bus ();

  ad9963_dev_if i_dev_if (
    .trx_clk     (trx_clk),
    .rst_n_i     (rst_n_i),
    .trx_iq_i    (trx_iq_i),
    .trx_data_i  (trx_data_i),
    .adc_valid_o (adc_valid),
    .adc_data_o  (adc_data),
    .dac_valid_i (dac_valid),
    .dac_data_i  (dac_data),
    .tx_iq_o     (tx_iq_o),
    .tx_data_o   (tx_data_o)
  );

  ad9963_rx #(
    .ID (ID)
  ) i_rx (
    .trx_clk        (trx_clk),
    .rst_n_i        (rst_n_i),
    .adc_valid_i    (adc_valid),
    .adc_data_i     (adc_data),
    .adc_enable_i_o (adc_enable_i_o),
    .adc_valid_i_o  (adc_valid_i_o),
    .adc_data_i_o   (adc_data_i_o),
    .adc_enable_q_o (adc_enable_q_o),
    .adc_valid_q_o  (adc_valid_q_o),
    .adc_data_q_o   (adc_data_q_o),
    .adc_dovf_i     (adc_dovf_i),
    .up             (up_rx_bus.bank)
  );

  ad9963_tx i_tx (
    .trx_clk        (trx_clk),
    .rst_n_i        (rst_n_i),
    .adc_valid_i    (adc_valid),
    .adc_data_i     (adc_data),
    .dac_enable_i_o (dac_enable_i_o),
    .dac_valid_i_o  (dac_valid_i_o),
    .dac_data_i_i   (dac_data_i_i),
    .dac_enable_q_o (dac_enable_q_o),
    .dac_valid_q_o  (dac_valid_q_o),
    .dac_data_q_i   (dac_data_q_i),
    .dac_dunf_i     (dac_dunf_i),
    .dac_valid_o    (dac_valid),
    .dac_data_o     (dac_data),
    .up             (up_tx_bus.bank)
  );

  up_axi i_up_axi (
    .trx_clk         (trx_clk),
    .rst_n_i         (rst_n_i),
    .s_axi_awvalid_i (s_axi_awvalid_i),
    .s_axi_awaddr_i  (s_axi_awaddr_i),
    .s_axi_awprot_i  (s_axi_awprot_i),
    .s_axi_awready_o (s_axi_awready_o),
    .s_axi_wvalid_i  (s_axi_wvalid_i),
    .s_axi_wdata_i   (s_axi_wdata_i),
    .s_axi_wstrb_i   (s_axi_wstrb_i),
    .s_axi_wready_o  (s_axi_wready_o),
    .s_axi_bvalid_o  (s_axi_bvalid_o),
    .s_axi_bresp_o   (s_axi_bresp_o),
    .s_axi_bready_i  (s_axi_bready_i),
    .s_axi_arvalid_i (s_axi_arvalid_i),
    .s_axi_araddr_i  (s_axi_araddr_i),
    .s_axi_arprot_i  (s_axi_arprot_i),
    .s_axi_arready_o (s_axi_arready_o),
    .s_axi_rvalid_o  (s_axi_rvalid_o),
    .s_axi_rdata_o   (s_axi_rdata_o),
    .s_axi_rresp_o   (s_axi_rresp_o),
    .s_axi_rready_i  (s_axi_rready_i),
    .up_rx           (up_rx_bus.bridge),
    .up_tx           (up_tx_bus.bridge)
  );

endmodule

// ==== ad9963_dev_if.sv ====
module ad9963_dev_if (
  input  logic                              trx_clk,
  input  logic                              rst_n_i,
  // converter receive bus
  input  logic                              trx_iq_i,
  input  logic [ad9963_pkg::SAMPLE_W-1:0]   trx_data_i,
  output logic                              adc_valid_o,
  output logic [2*ad9963_pkg::SAMPLE_W-1:0] adc_data_o,
  // transmit pair from the channel block
  input  logic                              dac_valid_i,
  input  logic [2*ad9963_pkg::SAMPLE_W-1:0] dac_data_i,
  output logic                              tx_iq_o,
  output logic [ad9963_pkg::SAMPLE_W-1:0]   tx_data_o
);

  localparam int SW = ad9963_pkg::SAMPLE_W;

  logic          iq_d;
  logic [SW-1:0] i_hold;
  logic [SW-1:0] q_hold;

  // ******************************
  // receive pairing
  // ******************************

  // a q sample right after an i sample completes the pair
  always_ff @(posedge trx_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      iq_d        <= 1'b0;
      adc_valid_o <= 1'b0;
    end else begin
      iq_d        <= trx_iq_i;
      adc_valid_o <= iq_d & ~trx_iq_i;
    end
  end

  always_ff @(posedge trx_clk) begin
    if (trx_iq_i) begin
      i_hold <= trx_data_i;
    end
    // q in the upper half
    adc_data_o <= {trx_data_i, i_hold};
  end

  // ******************************
  // transmit serializer
  // ******************************

  always_ff @(posedge trx_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tx_iq_o   <= 1'b0;
      tx_data_o <= '0;
    end else if (dac_valid_i) begin
      tx_iq_o   <= 1'b1;
      tx_data_o <= dac_data_i[SW-1:0];
    end else if (tx_iq_o) begin
      tx_iq_o   <= 1'b0;
      tx_data_o <= q_hold;
    end
  end

  always_ff @(posedge trx_clk) begin
    if (dac_valid_i) begin
      q_hold <= dac_data_i[2*SW-1:SW];
    end
  end

endmodule

// ==== ad9963_pkg.sv ====
package ad9963_pkg;

  // ******************************
  // widths
  // ******************************

  localparam int SAMPLE_W = 12;
  localparam int DMA_W    = 16;
  localparam int ADDR_W   = 14;
  localparam int DATA_W   = 32;

  // each bank owns 2**BANK_AW word addresses
  localparam int BANK_AW = 4;

  // low byte is filled with the instance id
  localparam logic [DATA_W-1:0] VERSION = 32'h0001_0200;

  // ******************************
  // register map
  // ******************************

  localparam logic [ADDR_W-1:0] RX_BASE = 14'h0000;
  localparam logic [ADDR_W-1:0] TX_BASE = 14'h0010;

  localparam logic [ADDR_W-1:0] REG_RX_VERSION = 14'h0000;
  localparam logic [ADDR_W-1:0] REG_RX_CNTRL   = 14'h0001;
  localparam logic [ADDR_W-1:0] REG_RX_STATUS  = 14'h0002;
  localparam logic [ADDR_W-1:0] REG_TX_CNTRL   = 14'h0011;
  localparam logic [ADDR_W-1:0] REG_TX_CONST   = 14'h0012;
  localparam logic [ADDR_W-1:0] REG_TX_STATUS  = 14'h0013;

  // field positions
  localparam int CNTRL_EN_I   = 0;
  localparam int CNTRL_EN_Q   = 1;
  localparam int CNTRL_FORMAT = 2;
  localparam int CNTRL_SRC    = 2;
  localparam int CONST_I      = 0;
  localparam int CONST_Q      = 16;
  localparam int STATUS_FLAG  = 0;

  // transmit source select where code 3 falls back to dma
  localparam logic [1:0] SRC_DMA      = 2'd0;
  localparam logic [1:0] SRC_CONST    = 2'd1;
  localparam logic [1:0] SRC_LOOPBACK = 2'd2;

endpackage

// ==== ad9963_rx.sv ====
module ad9963_rx #(
  parameter int ID = 0
) (
  input  logic                              trx_clk,
  input  logic                              rst_n_i,
  input  logic                              adc_valid_i,
  input  logic [2*ad9963_pkg::SAMPLE_W-1:0] adc_data_i,
  // dma side
  output logic                              adc_enable_i_o,
  output logic                              adc_valid_i_o,
  output logic [ad9963_pkg::DMA_W-1:0]      adc_data_i_o,
  output logic                              adc_enable_q_o,
  output logic                              adc_valid_q_o,
  output logic [ad9963_pkg::DMA_W-1:0]      adc_data_q_o,
  input  logic                              adc_dovf_i,
  up_bus_if.bank                            up
);

  localparam int SW = ad9963_pkg::SAMPLE_W;
  localparam int DW = ad9963_pkg::DMA_W;
  localparam int AW = ad9963_pkg::ADDR_W;
  localparam int BW = ad9963_pkg::BANK_AW;
  localparam int RW = ad9963_pkg::DATA_W;

  logic [2:0]    cntrl;
  logic          ovf;
  logic          ovf_clr;
  logic          own_read;
  logic [RW-1:0] rd_word;

  // offset binary to two's complement, then sign extend
  function automatic logic [DW-1:0] convert(input logic [SW-1:0] s, input logic ob);
    logic [SW-1:0] c;
    c         = s;
    c[SW-1]   = s[SW-1] ^ ob;
    return {{(DW-SW){c[SW-1]}}, c};
  endfunction

  assign adc_enable_i_o = cntrl[ad9963_pkg::CNTRL_EN_I];
  assign adc_enable_q_o = cntrl[ad9963_pkg::CNTRL_EN_Q];

  assign ovf_clr = up.wreq && up.waddr == ad9963_pkg::REG_RX_STATUS &&
                   up.wdata[ad9963_pkg::STATUS_FLAG];
  assign own_read = up.rreq && up.raddr[AW-1:BW] == ad9963_pkg::RX_BASE[AW-1:BW];

  // ******************************
  // registers
  // ******************************

  always_comb begin
    rd_word = '0;
    case (up.raddr)
      ad9963_pkg::REG_RX_VERSION: rd_word = ad9963_pkg::VERSION | RW'(8'(ID));
      ad9963_pkg::REG_RX_CNTRL:   rd_word = RW'(cntrl);
      ad9963_pkg::REG_RX_STATUS:  rd_word = RW'(ovf);
      default:                    rd_word = '0;
    endcase
  end

  always_ff @(posedge trx_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cntrl    <= '0;
      ovf      <= 1'b0;
      up.rdata <= '0;
    end else begin
      if (up.wreq && up.waddr == ad9963_pkg::REG_RX_CNTRL) begin
        cntrl <= up.wdata[2:0];
      end
      // a new overflow wins over the clear
      ovf      <= (ovf & ~ovf_clr) | adc_dovf_i;
      up.rdata <= own_read ? rd_word : '0;
    end
  end

  // ******************************
  // channel outputs
  // ******************************

  always_ff @(posedge trx_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      adc_valid_i_o <= 1'b0;
      adc_valid_q_o <= 1'b0;
    end else begin
      adc_valid_i_o <= adc_valid_i & adc_enable_i_o;
      adc_valid_q_o <= adc_valid_i & adc_enable_q_o;
    end
  end

  always_ff @(posedge trx_clk) begin
    if (adc_valid_i) begin
      adc_data_i_o <= convert(adc_data_i[SW-1:0], cntrl[ad9963_pkg::CNTRL_FORMAT]);
      adc_data_q_o <= convert(adc_data_i[2*SW-1:SW], cntrl[ad9963_pkg::CNTRL_FORMAT]);
    end
  end

endmodule

// ==== ad9963_tx.sv ====
module ad9963_tx (
  input  logic                              trx_clk,
  input  logic                              rst_n_i,
  // receive pair for loopback
  input  logic                              adc_valid_i,
  input  logic [2*ad9963_pkg::SAMPLE_W-1:0] adc_data_i,
  // dma side
  output logic                              dac_enable_i_o,
  output logic                              dac_valid_i_o,
  input  logic [ad9963_pkg::DMA_W-1:0]      dac_data_i_i,
  output logic                              dac_enable_q_o,
  output logic                              dac_valid_q_o,
  input  logic [ad9963_pkg::DMA_W-1:0]      dac_data_q_i,
  input  logic                              dac_dunf_i,
  // pair towards the serializer
  output logic                              dac_valid_o,
  output logic [2*ad9963_pkg::SAMPLE_W-1:0] dac_data_o,
  up_bus_if.bank                            up
);

  localparam int SW = ad9963_pkg::SAMPLE_W;
  localparam int DW = ad9963_pkg::DMA_W;
  localparam int AW = ad9963_pkg::ADDR_W;
  localparam int BW = ad9963_pkg::BANK_AW;
  localparam int RW = ad9963_pkg::DATA_W;

  logic [3:0]      cntrl;
  logic [1:0]      src;
  logic [SW-1:0]   const_i;
  logic [SW-1:0]   const_q;
  logic            unf;
  logic            unf_clr;
  logic            req;
  logic [2*SW-1:0] loop_pair;
  logic [2*SW-1:0] sel_pair;
  logic            own_read;
  logic [RW-1:0]   rd_word;

  assign dac_enable_i_o = cntrl[ad9963_pkg::CNTRL_EN_I];
  assign dac_enable_q_o = cntrl[ad9963_pkg::CNTRL_EN_Q];
  assign src            = cntrl[ad9963_pkg::CNTRL_SRC +: 2];
  assign dac_valid_i_o  = req & dac_enable_i_o;
  assign dac_valid_q_o  = req & dac_enable_q_o;

  assign unf_clr = up.wreq && up.waddr == ad9963_pkg::REG_TX_STATUS &&
                   up.wdata[ad9963_pkg::STATUS_FLAG];
  assign own_read = up.rreq && up.raddr[AW-1:BW] == ad9963_pkg::TX_BASE[AW-1:BW];

  // ******************************
  // registers
  // ******************************

  always_comb begin
    rd_word = '0;
    case (up.raddr)
      ad9963_pkg::REG_TX_CNTRL: rd_word = RW'(cntrl);
      ad9963_pkg::REG_TX_CONST: begin
        rd_word[ad9963_pkg::CONST_I +: SW] = const_i;
        rd_word[ad9963_pkg::CONST_Q +: SW] = const_q;
      end
      ad9963_pkg::REG_TX_STATUS: rd_word = RW'(unf);
      default: rd_word = '0;
    endcase
  end

  always_ff @(posedge trx_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cntrl    <= '0;
      const_i  <= '0;
      const_q  <= '0;
      unf      <= 1'b0;
      up.rdata <= '0;
    end else begin
      if (up.wreq && up.waddr == ad9963_pkg::REG_TX_CNTRL) begin
        cntrl <= up.wdata[3:0];
      end
      if (up.wreq && up.waddr == ad9963_pkg::REG_TX_CONST) begin
        const_i <= up.wdata[ad9963_pkg::CONST_I +: SW];
        const_q <= up.wdata[ad9963_pkg::CONST_Q +: SW];
      end
      unf      <= (unf & ~unf_clr) | dac_dunf_i;
      up.rdata <= own_read ? rd_word : '0;
    end
  end

  // ******************************
  // pacing and source select
  // ******************************

  always_comb begin
    case (src)
      ad9963_pkg::SRC_CONST:    sel_pair = {const_q, const_i};
      ad9963_pkg::SRC_LOOPBACK: sel_pair = loop_pair;
      // dma words are msb aligned
      default: sel_pair = {dac_data_q_i[DW-1:DW-SW], dac_data_i_i[DW-1:DW-SW]};
    endcase
    if (!dac_enable_i_o) begin
      sel_pair[SW-1:0] = '0;
    end
    if (!dac_enable_q_o) begin
      sel_pair[2*SW-1:SW] = '0;
    end
  end

  always_ff @(posedge trx_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req         <= 1'b0;
      dac_valid_o <= 1'b0;
    end else begin
      req         <= ~req;
      dac_valid_o <= req;
    end
  end

  always_ff @(posedge trx_clk) begin
    if (adc_valid_i) begin
      loop_pair <= adc_data_i;
    end
    if (req) begin
      dac_data_o <= sel_pair;
    end
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_ad9963 \
  -f sim.f \
  -o tb_ad9963

# a fatal exit is judged by the log below
./obj_dir/tb_ad9963 | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi
exit 0

// ==== sim.f ====
ad9963_pkg.sv
up_bus_if.sv
ad9963_dev_if.sv
ad9963_rx.sv
ad9963_tx.sv
up_axi.sv
ad9963_core.sv
tb_ad9963.sv

// ==== tb_ad9963.sv ====
module tb_ad9963;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD  = 4;
  localparam int STIM_CYCLES = 1200;
  localparam int SW = ad9963_pkg::SAMPLE_W;
  localparam int DW = ad9963_pkg::DMA_W;
  localparam int RW = ad9963_pkg::DATA_W;

  logic          trx_clk = 1'b0;
  logic          rst_n = 1'b0;
  logic          trx_iq, tx_iq;
  logic [SW-1:0] trx_data, tx_data;
  logic          adc_en_i, adc_vld_i, adc_en_q, adc_vld_q, adc_dovf;
  logic [DW-1:0] adc_d_i, adc_d_q;
  logic          dac_en_i, dac_vld_i, dac_en_q, dac_vld_q, dac_dunf;
  logic [DW-1:0] dac_d_i, dac_d_q;
  logic          awvalid, awready, wvalid, wready, bvalid, bready;
  logic          arvalid, arready, rvalid, rready;
  logic [31:0]   awaddr, araddr;
  logic [RW-1:0] wdata, rdata;
  logic [1:0]    bresp, rresp;

  // register mirrors follow each accepted write
  logic [2:0]    rx_cntrl = '0;
  logic [3:0]    tx_cntrl = '0;
  logic [SW-1:0] cst_i = '0;
  logic [SW-1:0] cst_q = '0;
  logic [31:0]   lfsr = 32'h3986;
  int            cyc = 0;
  logic          tx_chk = 1'b0;
  int            tx_pairs = 0;
  logic [DW-1:0] exp_i[$], exp_q[$];
  int            stamp_i[$], stamp_q[$];
  logic [2*SW-1:0] raw_pairs[$];
  // transmit capture history of valid, loopback flag and pair
  logic          h_vld[2] = '{1'b0, 1'b0};
  logic          h_loop[2];
  logic [2*SW-1:0] h_pair[2];
  logic          pend;
  logic          pend_loop;
  logic [2*SW-1:0] pend_pair;
  logic [SW-1:0] pend_i;
  logic          found;
  logic [DW-1:0] got;
  int            got_stamp;

  always #(CLK_PERIOD / 2) trx_clk = ~trx_clk;

  ad9963_core #(.ID(5)) i_ad9963_core (
    .trx_clk (trx_clk), .rst_n_i (rst_n),
    .trx_iq_i (trx_iq), .trx_data_i (trx_data), .tx_iq_o (tx_iq), .tx_data_o (tx_data),
    .adc_enable_i_o (adc_en_i), .adc_valid_i_o (adc_vld_i), .adc_data_i_o (adc_d_i),
    .adc_enable_q_o (adc_en_q), .adc_valid_q_o (adc_vld_q), .adc_data_q_o (adc_d_q),
    .adc_dovf_i (adc_dovf),
    .dac_enable_i_o (dac_en_i), .dac_valid_i_o (dac_vld_i), .dac_data_i_i (dac_d_i),
    .dac_enable_q_o (dac_en_q), .dac_valid_q_o (dac_vld_q), .dac_data_q_i (dac_d_q),
    .dac_dunf_i (dac_dunf),
    .s_axi_awvalid_i (awvalid), .s_axi_awaddr_i (awaddr), .s_axi_awprot_i (3'b000),
    .s_axi_awready_o (awready), .s_axi_wvalid_i (wvalid), .s_axi_wdata_i (wdata),
    .s_axi_wstrb_i (4'hf), .s_axi_wready_o (wready), .s_axi_bvalid_o (bvalid),
    .s_axi_bresp_o (bresp), .s_axi_bready_i (bready), .s_axi_arvalid_i (arvalid),
    .s_axi_araddr_i (araddr), .s_axi_arprot_i (3'b000), .s_axi_arready_o (arready),
    .s_axi_rvalid_o (rvalid), .s_axi_rdata_o (rdata), .s_axi_rresp_o (rresp),
    .s_axi_rready_i (rready)
  );

  task automatic report_error(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    $display("Simulation FAILED");
    $fatal(1, "check failed");
  endtask

  // galois lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] r);
    r = '0;
    for (int b = 0; b < n; b++) begin
      lfsr = lfsr_step(lfsr);
      r    = {r[30:0], lfsr[0]};
    end
  endtask

  // offset binary moves by half scale before sign extension
  function automatic logic [DW-1:0] rx_model(input logic [SW-1:0] s, input logic ob);
    logic [SW-1:0] c;
    c = ob ? s + 12'h800 : s;
    return {{(DW-SW){c[SW-1]}}, c};
  endfunction

  task automatic step(input int n = 1);
    repeat (n) @(posedge trx_clk);
    #1;
  endtask

  // ******************************
  // axi-lite access
  // ******************************

  task automatic axi_write(input logic [13:0] addr, input logic [31:0] data);
    awvalid = 1'b1;
    wvalid  = 1'b1;
    awaddr  = {16'h0, addr, 2'b00};
    wdata   = data;
    do @(posedge trx_clk); while (!(awready && wready));
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    // the register takes the new value at the accepting edge
    if (addr == ad9963_pkg::REG_RX_CNTRL) rx_cntrl = data[2:0];
    if (addr == ad9963_pkg::REG_TX_CNTRL) tx_cntrl = data[3:0];
    if (addr == ad9963_pkg::REG_TX_CONST) {cst_q, cst_i} = {data[27:16], data[11:0]};
    do @(posedge trx_clk); while (!bvalid);
    assert (bresp == 2'b00) else report_error("write response not OKAY");
    #1;
    bready = 1'b0;
  endtask

  task automatic axi_read_check(input logic [13:0] addr, input logic [31:0] expected);
    arvalid = 1'b1;
    araddr  = {16'h0, addr, 2'b00};
    do @(posedge trx_clk); while (!arready);
    #1;
    arvalid = 1'b0;
    rready  = 1'b1;
    do @(posedge trx_clk); while (!rvalid);
    assert (rresp == 2'b00) else report_error("read response not OKAY");
    assert (rdata == expected)
      else report_error($sformatf("read 0x%0h got 0x%0h exp 0x%0h", addr, rdata, expected));
    #1;
    rready = 1'b0;
  endtask

  // ******************************
  // stimulus helpers
  // ******************************

  task automatic send_pairs(input int n);
    logic [31:0] r;
    logic [SW-1:0] si, sq;
    for (int k = 0; k < n; k++) begin
      rand_bits(SW, r);
      si = r[SW-1:0];
      rand_bits(SW, r);
      sq = r[SW-1:0];
      trx_iq   = 1'b1;
      trx_data = si;
      step();
      trx_iq   = 1'b0;
      trx_data = sq;
      raw_pairs.push_back({sq, si});
      if (raw_pairs.size() > 16) void'(raw_pairs.pop_front());
      if (rx_cntrl[0]) begin
        exp_i.push_back(rx_model(si, rx_cntrl[2]));
        stamp_i.push_back(cyc + 2);
      end
      if (rx_cntrl[1]) begin
        exp_q.push_back(rx_model(sq, rx_cntrl[2]));
        stamp_q.push_back(cyc + 2);
      end
      step();
    end
    step(4);
    assert (exp_i.size() == 0 && exp_q.size() == 0)
      else report_error("receive samples missing on the dma side");
  endtask

  task automatic tx_phase(input logic [3:0] cntrl, input int rx_pairs);
    axi_write(ad9963_pkg::REG_TX_CNTRL, 32'(cntrl));
    step(6);
    tx_pairs = 0;
    tx_chk   = 1'b1;
    if (rx_pairs > 0) send_pairs(rx_pairs);
    else step(40);
    tx_chk = 1'b0;
    step(6);
    assert (tx_pairs > 5) else report_error("no transmit pairs were checked");
  endtask

  // new dma words every cycle
  always @(posedge trx_clk) begin
    logic [31:0] r;
    #1;
    rand_bits(DW, r);
    dac_d_i = r[DW-1:0];
    rand_bits(DW, r);
    dac_d_q = r[DW-1:0];
  end

  // ******************************
  // checkers
  // ******************************

  assert property (@(posedge trx_clk) disable iff (!rst_n) !adc_en_q |-> !adc_vld_q)
    else report_error("adc_valid_q pulsed while disabled");
  assert property (@(posedge trx_clk) disable iff (!rst_n) !adc_en_i |-> !adc_vld_i)
    else report_error("adc_valid_i pulsed while disabled");
  assert property (@(posedge trx_clk) disable iff (!rst_n) !dac_en_q |-> !dac_vld_q)
    else report_error("dac_valid_q pulsed while disabled");

  always @(posedge trx_clk) begin
    if (rst_n) begin
      assert (adc_en_i == rx_cntrl[0] && adc_en_q == rx_cntrl[1])
        else report_error("receive enables differ from control register");
      assert (dac_en_i == tx_cntrl[0] && dac_en_q == tx_cntrl[1])
        else report_error("transmit enables differ from control register");
      if (adc_vld_i) begin
        assert (exp_i.size() > 0) else report_error("unexpected adc_valid_i");
        got       = exp_i.pop_front();
        got_stamp = stamp_i.pop_front();
        assert (adc_d_i == got && got_stamp == cyc)
          else report_error($sformatf("adc_data_i 0x%0h exp 0x%0h", adc_d_i, got));
      end
      if (adc_vld_q) begin
        assert (exp_q.size() > 0) else report_error("unexpected adc_valid_q");
        got       = exp_q.pop_front();
        got_stamp = stamp_q.pop_front();
        assert (adc_d_q == got && got_stamp == cyc)
          else report_error($sformatf("adc_data_q 0x%0h exp 0x%0h", adc_d_q, got));
      end
      // q slot closes the pair started by the i slot
      if (!tx_iq && pend) begin
        found = !pend_loop && {tx_data, pend_i} == pend_pair;
        foreach (raw_pairs[k]) begin
          if (pend_loop && raw_pairs[k] == {tx_data, pend_i}) found = 1'b1;
        end
        assert (found)
          else report_error($sformatf("tx pair 0x%0h/0x%0h exp 0x%0h",
                                      tx_data, pend_i, pend_pair));
        tx_pairs++;
      end
      pend = tx_iq && h_vld[1];
      if (tx_iq) begin
        pend_i    = tx_data;
        pend_loop = h_loop[1];
        pend_pair = h_pair[1];
      end
      h_vld[1]  = h_vld[0];
      h_loop[1] = h_loop[0];
      h_pair[1] = h_pair[0];
      h_vld[0]  = tx_chk && (dac_vld_i || dac_vld_q);
      h_loop[0] = tx_cntrl[3:2] == ad9963_pkg::SRC_LOOPBACK;
      h_pair[0] = tx_cntrl[3:2] == ad9963_pkg::SRC_CONST ? {cst_q, cst_i} :
                  {dac_d_q[DW-1 -: SW], dac_d_i[DW-1 -: SW]};
      if (!tx_cntrl[0]) h_pair[0][SW-1:0] = '0;
      if (!tx_cntrl[1]) h_pair[0][2*SW-1:SW] = '0;
    end
    cyc++;
  end

  initial begin
    #(20 * STIM_CYCLES * CLK_PERIOD);
    $display("TIMEOUT: the run did not finish within %0d cycles", 20 * STIM_CYCLES);
    $display("Simulation FAILED");
    $fatal(1, "timeout");
  end

  // ******************************
  // test sequence
  // ******************************

  initial begin
    {trx_iq, trx_data, adc_dovf, dac_dunf, dac_d_i, dac_d_q} = '0;
    {awvalid, wvalid, bready, arvalid, rready, awaddr, araddr, wdata} = '0;
    pend = 1'b0;
    repeat (4) @(posedge trx_clk);
    #1;
    rst_n = 1'b1;
    step(2);

    // register access
    axi_read_check(ad9963_pkg::REG_RX_VERSION, ad9963_pkg::VERSION | 32'd5);
    axi_write(ad9963_pkg::REG_TX_CONST, 32'h0abc_0123);
    axi_read_check(ad9963_pkg::REG_TX_CONST, 32'h0abc_0123);
    axi_write(ad9963_pkg::REG_RX_CNTRL, 32'h5);
    axi_read_check(ad9963_pkg::REG_RX_CNTRL, 32'h5);
    axi_read_check(14'h0005, 32'h0);
    axi_read_check(14'h0020, 32'h0);

    // receive conversion and enables
    axi_write(ad9963_pkg::REG_RX_CNTRL, 32'h7);
    send_pairs(40);
    axi_write(ad9963_pkg::REG_RX_CNTRL, 32'h3);
    send_pairs(30);
    axi_write(ad9963_pkg::REG_RX_CNTRL, 32'h1);
    send_pairs(20);
    axi_write(ad9963_pkg::REG_RX_CNTRL, 32'h2);
    send_pairs(20);

    // transmit sources
    axi_write(ad9963_pkg::REG_RX_CNTRL, 32'h3);
    tx_phase({ad9963_pkg::SRC_DMA, 2'b11}, 0);
    tx_phase({ad9963_pkg::SRC_DMA, 2'b01}, 0);
    tx_phase({ad9963_pkg::SRC_CONST, 2'b11}, 0);
    tx_phase({ad9963_pkg::SRC_LOOPBACK, 2'b11}, 30);
    axi_write(ad9963_pkg::REG_TX_CNTRL, 32'h0);

    // sticky status
    adc_dovf = 1'b1;
    step();
    adc_dovf = 1'b0;
    axi_read_check(ad9963_pkg::REG_RX_STATUS, 32'h1);
    axi_write(ad9963_pkg::REG_RX_STATUS, 32'h1);
    axi_read_check(ad9963_pkg::REG_RX_STATUS, 32'h0);
    dac_dunf = 1'b1;
    step();
    dac_dunf = 1'b0;
    axi_read_check(ad9963_pkg::REG_TX_STATUS, 32'h1);
    axi_write(ad9963_pkg::REG_TX_STATUS, 32'h1);
    axi_read_check(ad9963_pkg::REG_TX_STATUS, 32'h0);

    step(4);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== up_axi.sv ====
module up_axi (
  input  logic                          trx_clk,
  input  logic                          rst_n_i,
  // write address and data
  input  logic                          s_axi_awvalid_i,
  input  logic [31:0]                   s_axi_awaddr_i,
  input  logic [2:0]                    s_axi_awprot_i,
  output logic                          s_axi_awready_o,
  input  logic                          s_axi_wvalid_i,
  input  logic [ad9963_pkg::DATA_W-1:0] s_axi_wdata_i,
  input  logic [3:0]                    s_axi_wstrb_i,
  output logic                          s_axi_wready_o,
  // write response
  output logic                          s_axi_bvalid_o,
  output logic [1:0]                    s_axi_bresp_o,
  input  logic                          s_axi_bready_i,
  // read
  input  logic                          s_axi_arvalid_i,
  input  logic [31:0]                   s_axi_araddr_i,
  input  logic [2:0]                    s_axi_arprot_i,
  output logic                          s_axi_arready_o,
  output logic                          s_axi_rvalid_o,
  output logic [ad9963_pkg::DATA_W-1:0] s_axi_rdata_o,
  output logic [1:0]                    s_axi_rresp_o,
  input  logic                          s_axi_rready_i,
  up_bus_if.bridge                      up_rx,
  up_bus_if.bridge                      up_tx
);

  localparam int AW = ad9963_pkg::ADDR_W;

  logic          wr_go;
  logic          rd_go;
  logic          rd_wait;
  logic [AW-1:0] waddr;
  logic [AW-1:0] raddr;

  // prot and strobes are not used, every access is a full word
  assign wr_go = s_axi_awvalid_i & s_axi_wvalid_i & ~s_axi_bvalid_o;
  assign rd_go = s_axi_arvalid_i & ~rd_wait & ~s_axi_rvalid_o;

  // byte to word address
  assign waddr = s_axi_awaddr_i[AW+1:2];
  assign raddr = s_axi_araddr_i[AW+1:2];

  assign s_axi_awready_o = wr_go;
  assign s_axi_wready_o  = wr_go;
  assign s_axi_arready_o = rd_go;
  assign s_axi_bresp_o   = 2'b00;
  assign s_axi_rresp_o   = 2'b00;

  // ******************************
  // same request into both banks
  // ******************************

  assign up_rx.wreq  = wr_go;
  assign up_rx.waddr = waddr;
  assign up_rx.wdata = s_axi_wdata_i;
  assign up_rx.rreq  = rd_go;
  assign up_rx.raddr = raddr;

  assign up_tx.wreq  = wr_go;
  assign up_tx.waddr = waddr;
  assign up_tx.wdata = s_axi_wdata_i;
  assign up_tx.rreq  = rd_go;
  assign up_tx.raddr = raddr;

  // ******************************
  // responses
  // ******************************

  always_ff @(posedge trx_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s_axi_bvalid_o <= 1'b0;
      s_axi_rvalid_o <= 1'b0;
      rd_wait        <= 1'b0;
    end else begin
      if (wr_go) begin
        s_axi_bvalid_o <= 1'b1;
      end else if (s_axi_bready_i) begin
        s_axi_bvalid_o <= 1'b0;
      end
      // banks answer one cycle after rreq
      rd_wait <= rd_go;
      if (rd_wait) begin
        s_axi_rvalid_o <= 1'b1;
      end else if (s_axi_rready_i) begin
        s_axi_rvalid_o <= 1'b0;
      end
    end
  end

  // unowned banks return zero, so OR is the merge
  always_ff @(posedge trx_clk) begin
    if (rd_wait) begin
      s_axi_rdata_o <= up_rx.rdata | up_tx.rdata;
    end
  end

endmodule

// ==== up_bus_if.sv ====
interface up_bus_if;

  // single cycle write request
  logic                            wreq;
  logic [ad9963_pkg::ADDR_W-1:0]   waddr;
  logic [ad9963_pkg::DATA_W-1:0]   wdata;

  // read request with data one cycle later
  logic                            rreq;
  logic [ad9963_pkg::ADDR_W-1:0]   raddr;
  logic [ad9963_pkg::DATA_W-1:0]   rdata;

  modport bridge (
    output wreq, waddr, wdata,
    output rreq, raddr,
    input  rdata
  );

  modport bank (
    input  wreq, waddr, wdata,
    input  rreq, raddr,
    output rdata
  );

endinterface
